// ==== verilog/vrf_macros.svh ====
`ifndef VRF_MACROS_SVH
`define VRF_MACROS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// One register-file word per memory access
`define VRF_XLEN 32

// One enable per byte of the word
`define VRF_BE_W 4

// Vector length as delivered by the CSR
`define VRF_VL_W 32

// Byte count without its two low bits
`define VRF_ITER_W 30

`endif

// ==== verilog/vrf_pkg.sv ====
package vrf_pkg;

  // Element width code, doubles as byte shift amount
  typedef enum logic [1:0] {
    VSEW_8  = 2'd0,
    VSEW_16 = 2'd1,
    VSEW_32 = 2'd2,
    VSEW_64 = 2'd3
  } vsew_e;

  // Operation select, rd_rs1 sits in bit 0
  typedef struct packed {
    logic wr_rd;
    logic rd_rs2;
    logic rd_rs1;
  } vrf_sel_t;

  // Access sequencer states
  typedef enum logic [2:0] {
    VRF_IDLE  = 3'd0,
    VRF_START = 3'd1,
    VRF_READ1 = 3'd2,
    VRF_READ2 = 3'd3,
    VRF_WRITE = 3'd4
  } vrf_state_e;

endpackage

// ==== verilog/vrf_iter_if.sv ====
`timescale 1ns/1ps
`include "vrf_macros.svh"

interface vrf_iter_if;

  // Strobes from the sequencer
  logic                 load;
  logic                 step;

  // Levels from the iteration counter
  logic                 last;
  logic                 empty;
  logic [`VRF_BE_W-1:0] be;

  modport seq (
    output load, step,
    input  last, empty, be
  );

  modport cnt (
    input  load, step,
    output last, empty, be
  );

endinterface

// ==== verilog/vrf_iter_counter.sv ====
`timescale 1ns/1ps
`include "vrf_macros.svh"

module vrf_iter_counter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [`VRF_VL_W-1:0]  vl_i,
  input  vrf_pkg::vsew_e        sew_i,
  vrf_iter_if.cnt               iter_if
);

  logic [`VRF_VL_W-1:0]   byte_cnt;
  logic [`VRF_ITER_W-1:0] word_cnt;
  logic [`VRF_ITER_W-1:0] iter_q;
  logic [1:0]             tail_q;
  logic [`VRF_BE_W-1:0]   tail_be;

  ////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////

  assign byte_cnt = vl_i << sew_i;

  // Partial last word still costs a full iteration
  assign word_cnt = byte_cnt[`VRF_VL_W-1:2] + `VRF_ITER_W'(|byte_cnt[1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iter_q <= '0;
      tail_q <= 2'd0;
    end else if (iter_if.load) begin
      iter_q <= word_cnt;
      tail_q <= byte_cnt[1:0];
    end else if (iter_if.step) begin
      iter_q <= iter_q - `VRF_ITER_W'(1);
    end
  end

  ////////////////////////////////////////
  // Status and byte enables
  ////////////////////////////////////////

  assign iter_if.last  = (iter_q == `VRF_ITER_W'(1));
  assign iter_if.empty = (iter_q == '0);

  // Low bytes of the tail word only
  always_comb begin
    case (tail_q)
      2'd1:    tail_be = 4'b0001;
      2'd2:    tail_be = 4'b0011;
      2'd3:    tail_be = 4'b0111;
      default: tail_be = 4'b1111;
    endcase
  end

  // Full word everywhere but a ragged final iteration
  assign iter_if.be = (iter_if.last && (tail_q != 2'd0)) ? tail_be : '1;

endmodule

// ==== verilog/vrf_operand_regs.sv ====
`timescale 1ns/1ps
`include "vrf_macros.svh"

module vrf_operand_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rs1_en_i,
  input  logic                 rs2_en_i,
  input  logic [`VRF_XLEN-1:0] data_rdata_i,
  output logic [`VRF_XLEN-1:0] rdata_a_o,
  output logic [`VRF_XLEN-1:0] rdata_b_o
);

  logic [`VRF_XLEN-1:0] rs1_q;
  logic [`VRF_XLEN-1:0] rs2_q;

  ////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else begin
      if (rs1_en_i) begin
        rs1_q <= data_rdata_i;
      end
      if (rs2_en_i) begin
        rs2_q <= data_rdata_i;
      end
    end
  end

  // Operands to the execution pipe
  assign rdata_a_o = rs1_q;
  assign rdata_b_o = rs2_q;

endmodule

// ==== verilog/vrf_access_fsm.sv ====
`timescale 1ns/1ps

module vrf_access_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  vrf_pkg::vrf_sel_t sel_operation_i,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  vrf_iter_if.seq           iter_if,
  output logic              data_req_o,
  output logic              data_we_o,
  output logic              agu_load_o,
  output logic              agu_get_rs1_o,
  output logic              agu_get_rs2_o,
  output logic              agu_get_rd_o,
  output logic              agu_incr_o,
  output logic              rs1_en_o,
  output logic              rs2_en_o,
  output logic              vector_done_o
);

  import vrf_pkg::*;

  vrf_state_e state_q, state_d;
  vrf_sel_t   sel_q;
  logic       want_rs1, want_rs2, want_rd;
  logic       want_any;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= VRF_IDLE;
      sel_q <= '0;
    end else begin
      state_q <= state_d;
      // Select is held for the whole vector
      if (state_q == VRF_IDLE && req_i) begin
        sel_q <= sel_operation_i;
      end
    end
  end

  ////////////////////////////////////////
  // Next access of the iteration
  ////////////////////////////////////////

  // Order within one iteration is rs1, rs2, rd
  always_comb begin
    want_rs1 = 1'b0;
    want_rs2 = 1'b0;
    want_rd  = 1'b0;
    case (state_q)
      VRF_START: begin
        if (!iter_if.empty) begin
          want_rs1 = sel_q.rd_rs1;
          want_rs2 = !sel_q.rd_rs1 && sel_q.rd_rs2;
          want_rd  = !sel_q.rd_rs1 && !sel_q.rd_rs2 && sel_q.wr_rd;
        end
      end
      VRF_READ1: begin
        want_rs2 = sel_q.rd_rs2;
        want_rd  = !sel_q.rd_rs2 && sel_q.wr_rd;
      end
      VRF_READ2: begin
        want_rd = sel_q.wr_rd;
      end
      default: begin
        want_rd = 1'b0;
      end
    endcase
  end

  assign want_any = want_rs1 | want_rs2 | want_rd;

  // Request and its attributes stay put until granted
  assign data_req_o    = want_any;
  assign data_we_o     = want_rd;
  assign agu_get_rs1_o = want_rs1;
  assign agu_get_rs2_o = want_rs2;
  assign agu_get_rd_o  = want_rd;
  assign agu_incr_o    = want_any & data_gnt_i;

  // Read data lands in the state entered on its grant
  assign rs1_en_o = (state_q == VRF_READ1) & data_rvalid_i;
  assign rs2_en_o = (state_q == VRF_READ2) & data_rvalid_i;

  ////////////////////////////////////////
  // State transitions
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    agu_load_o    = 1'b0;
    iter_if.load  = 1'b0;
    iter_if.step  = 1'b0;
    vector_done_o = 1'b0;
    case (state_q)
      VRF_IDLE: begin
        if (req_i) begin
          agu_load_o   = 1'b1;
          iter_if.load = 1'b1;
          state_d      = VRF_START;
        end
      end
      VRF_START, VRF_READ1, VRF_READ2, VRF_WRITE: begin
        if (want_any) begin
          if (data_gnt_i) begin
            if (want_rs1) begin
              state_d = VRF_READ1;
            end else if (want_rs2) begin
              state_d = VRF_READ2;
            end else begin
              state_d = VRF_WRITE;
            end
          end
        end else if (state_q == VRF_START) begin
          // Zero length or nothing selected
          state_d = VRF_IDLE;
        end else if (iter_if.last) begin
          vector_done_o = 1'b1;
          state_d       = VRF_IDLE;
        end else begin
          iter_if.step = 1'b1;
          state_d      = VRF_START;
        end
      end
      default: begin
        state_d = VRF_IDLE;
      end
    endcase
  end

endmodule

// ==== verilog/vrf_access_top.sv ====
`timescale 1ns/1ps
`include "vrf_macros.svh"

module vrf_access_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  vrf_pkg::vrf_sel_t     sel_operation_i,
  input  vrf_pkg::vsew_e        sew_i,
  input  logic [`VRF_VL_W-1:0]  vl_i,
  input  logic [`VRF_XLEN-1:0]  wdata_i,
  // Register-file memory
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`VRF_XLEN-1:0]  data_rdata_i,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [`VRF_BE_W-1:0]  data_be_o,
  output logic [`VRF_XLEN-1:0]  data_wdata_o,
  // Address generator strobes
  output logic                  agu_load_o,
  output logic                  agu_get_rs1_o,
  output logic                  agu_get_rs2_o,
  output logic                  agu_get_rd_o,
  output logic                  agu_incr_o,
  // Execution pipe
  output logic [`VRF_XLEN-1:0]  rdata_a_o,
  output logic [`VRF_XLEN-1:0]  rdata_b_o,
  output logic                  vector_done_o
);

  logic rs1_en;
  logic rs2_en;

  vrf_iter_if iter_if ();

  vrf_access_fsm vrf_access_fsm_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .sel_operation_i (sel_operation_i),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .iter_if         (iter_if.seq),
    .data_req_o      (data_req_o),
    .data_we_o       (data_we_o),
    .agu_load_o      (agu_load_o),
    .agu_get_rs1_o   (agu_get_rs1_o),
    .agu_get_rs2_o   (agu_get_rs2_o),
    .agu_get_rd_o    (agu_get_rd_o),
    .agu_incr_o      (agu_incr_o),
    .rs1_en_o        (rs1_en),
    .rs2_en_o        (rs2_en),
    .vector_done_o   (vector_done_o)
  );

  vrf_iter_counter vrf_iter_counter_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .vl_i    (vl_i),
    .sew_i   (sew_i),
    .iter_if (iter_if.cnt)
  );

  vrf_operand_regs vrf_operand_regs_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rs1_en_i     (rs1_en),
    .rs2_en_i     (rs2_en),
    .data_rdata_i (data_rdata_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o)
  );

  // Byte enables follow the current iteration
  assign data_be_o = iter_if.be;

  // Write data comes straight from the pipe
  assign data_wdata_o = wdata_i;

endmodule

// ==== dv/tb_vrf_access.sv ====
`timescale 1ns/1ps
`include "vrf_macros.svh"

module tb_vrf_access;

  import vrf_pkg::*;

  localparam int NUM_VEC      = 16;
  localparam int DONE_TIMEOUT = 500;
  localparam int OP_RS1       = 0;
  localparam int OP_RS2       = 1;
  localparam int OP_RD        = 2;

  logic                 clk_i = 1'b0;
  logic                 rst_ni = 1'b0;
  logic                 req_i;
  vrf_sel_t             sel_operation_i;
  vsew_e                sew_i;
  logic [`VRF_VL_W-1:0] vl_i;
  logic [`VRF_XLEN-1:0] wdata_i = '0;
  logic                 data_gnt_i = 1'b0;
  logic                 data_rvalid_i = 1'b0;
  logic [`VRF_XLEN-1:0] data_rdata_i = '0;
  logic                 data_req_o, data_we_o;
  logic [`VRF_BE_W-1:0] data_be_o;
  logic [`VRF_XLEN-1:0] data_wdata_o, rdata_a_o, rdata_b_o;
  logic                 agu_load_o, agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o, agu_incr_o;
  logic                 vector_done_o;

  integer      seed = 26;
  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] rd_count = 32'd1;
  logic [31:0] vl_tab [NUM_VEC];
  logic [1:0]  sew_tab [NUM_VEC];
  logic [2:0]  sel_tab [NUM_VEC];

  // Expected accesses of the running request, oldest first
  int          exp_op_q [$];
  logic [3:0]  exp_be_q [$];
  int          exp_count, grants, rv_op, cap_op;
  logic        done_due, stall_q, rv_due, cap_due;
  logic [8:0]  prev_attr;
  logic [31:0] cap_data;

  vrf_access_top vrf_access_top_inst (.*);

  always #2 clk_i = ~clk_i;

  task report_mismatch(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    $display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
    errors++;
  endtask

  task report_problem(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  function automatic int decode_op(input logic rs1, input logic rs2, input logic rd);
    if (rs1) return OP_RS1;
    if (rs2) return OP_RS2;
    if (rd) return OP_RD;
    return 3;
  endfunction

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always @(posedge clk_i) begin : mem_model
    logic [31:0] rnd;
    rnd = $random(seed);
    data_rvalid_i <= 1'b0;
    // Read data answers one cycle after its grant
    if (rst_ni && data_req_o && data_gnt_i && !data_we_o) begin
      data_rvalid_i <= 1'b1;
      data_rdata_i  <= rd_count * 32'h0001_0003 + 32'h0BAD_0000;
      rd_count      <= rd_count + 32'd1;
    end
    data_gnt_i <= rst_ni && (rnd[1:0] != 2'b00);
    wdata_i    <= rnd ^ 32'h5A5A_0F0F;
  end

  ////////////////////////////////////////
  // Checks, sampled mid-cycle
  ////////////////////////////////////////

  always @(negedge clk_i) begin : access_check
    logic        hs;
    int          op, iters, it;
    logic [31:0] bytes;
    logic [3:0]  be_last, be;
    if (!rst_ni) begin
      assert ({data_req_o, vector_done_o, agu_load_o, agu_get_rs1_o, agu_get_rs2_o,
               agu_get_rd_o, agu_incr_o} == 7'd0)
        else report_mismatch("reset outputs", 32'd0,
                             32'({data_req_o, vector_done_o, agu_load_o, agu_get_rs1_o,
                                  agu_get_rs2_o, agu_get_rd_o, agu_incr_o}));
      exp_op_q.delete();
      exp_be_q.delete();
      done_due = 1'b0;
      stall_q  = 1'b0;
      rv_due   = 1'b0;
      cap_due  = 1'b0;
      grants   = 0;
    end else begin
      hs = data_req_o && data_gnt_i;
      op = decode_op(agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o);
      if (agu_load_o) begin
        // Word iterations and tail from vl and the element width
        bytes   = vl_i << sew_i;
        iters   = int'((bytes + 32'd3) >> 2);
        be_last = (bytes[1:0] == 2'd0) ? 4'hF : 4'((32'd1 << bytes[1:0]) - 32'd1);
        exp_op_q.delete();
        exp_be_q.delete();
        for (it = 0; it < iters; it++) begin
          be = (it == iters - 1) ? be_last : 4'hF;
          if (sel_operation_i.rd_rs1) begin
            exp_op_q.push_back(OP_RS1);
            exp_be_q.push_back(be);
          end
          if (sel_operation_i.rd_rs2) begin
            exp_op_q.push_back(OP_RS2);
            exp_be_q.push_back(be);
          end
          if (sel_operation_i.wr_rd) begin
            exp_op_q.push_back(OP_RD);
            exp_be_q.push_back(be);
          end
        end
        exp_count = exp_op_q.size();
        grants    = 0;
      end
      assert (!agu_load_o || req_i) else report_problem("agu_load_o pulsed without req_i");
      assert (agu_incr_o == hs) else report_mismatch("agu_incr", 32'(hs), 32'(agu_incr_o));
      assert (data_we_o == agu_get_rd_o)
        else report_mismatch("we_with_rd", 32'(agu_get_rd_o), 32'(data_we_o));
      assert ($countones({agu_get_rs1_o, agu_get_rs2_o, agu_get_rd_o}) == 32'(data_req_o))
        else report_problem("agu selects not one-hot with data_req_o");
      // A stalled request must not move
      if (stall_q) begin
        assert ({data_req_o, data_we_o, data_be_o, agu_get_rs1_o, agu_get_rs2_o,
                 agu_get_rd_o} == prev_attr)
          else report_mismatch("backpressure hold", 32'(prev_attr),
                               32'({data_req_o, data_we_o, data_be_o, agu_get_rs1_o,
                                    agu_get_rs2_o, agu_get_rd_o}));
      end
      assert (vector_done_o == done_due)
        else report_mismatch("done timing", 32'(done_due), 32'(vector_done_o));
      if (vector_done_o) begin
        assert (grants == exp_count)
          else report_mismatch("access count", 32'(exp_count), 32'(grants));
      end
      if (cap_due) begin
        if (cap_op == OP_RS1) begin
          assert (rdata_a_o == cap_data) else report_mismatch("rs1 capture", cap_data, rdata_a_o);
        end else begin
          assert (rdata_b_o == cap_data) else report_mismatch("rs2 capture", cap_data, rdata_b_o);
        end
      end
      cap_due = 1'b0;
      if (rv_due) begin
        cap_due  = 1'b1;
        cap_op   = rv_op;
        cap_data = data_rdata_i;
      end
      rv_due   = 1'b0;
      done_due = 1'b0;
      if (hs) begin
        grants++;
        if (exp_op_q.size() == 0) begin
          report_problem("access granted while none was expected");
        end else begin
          assert (op == exp_op_q[0]) else report_mismatch("access order", 32'(exp_op_q[0]),
                                                           32'(op));
          assert (data_be_o == exp_be_q[0])
            else report_mismatch("byte enables", 32'(exp_be_q[0]), 32'(data_be_o));
          if (op == OP_RD) begin
            assert (data_wdata_o == wdata_i)
              else report_mismatch("write data", wdata_i, data_wdata_o);
          end else begin
            rv_due = 1'b1;
            rv_op  = op;
          end
          void'(exp_op_q.pop_front());
          void'(exp_be_q.pop_front());
          done_due = (exp_op_q.size() == 0);
        end
      end
      stall_q   = data_req_o && !data_gnt_i;
      prev_attr = {data_req_o, data_we_o, data_be_o, agu_get_rs1_o, agu_get_rs2_o,
                   agu_get_rd_o};
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task set_vector(input int idx, input logic [31:0] vl, input logic [1:0] sew,
                  input logic [2:0] sel);
    vl_tab[idx]  = vl;
    sew_tab[idx] = sew;
    sel_tab[idx] = sel;
  endtask

  task run_vector(input int idx);
    logic [31:0] bytes;
    logic        got;
    int          cycles;
    bytes = vl_tab[idx] << sew_tab[idx];
    @(posedge clk_i);
    req_i           <= 1'b1;
    vl_i            <= vl_tab[idx];
    sew_i           <= vsew_e'(sew_tab[idx]);
    sel_operation_i <= vrf_sel_t'(sel_tab[idx]);
    @(posedge clk_i);
    req_i <= 1'b0;
    if (bytes == 32'd0 || sel_tab[idx] == 3'd0) begin
      // FSM falls back to idle straight from START
      repeat (4) @(posedge clk_i);
    end else begin
      got    = 1'b0;
      cycles = 0;
      while (!got && cycles < DONE_TIMEOUT) begin
        @(negedge clk_i);
        got = vector_done_o;
        cycles++;
      end
      if (!got) begin
        $display("Timeout: vector %0d never raised vector_done_o", idx);
        timeouts++;
      end
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    int          i;
    req_i           <= 1'b0;
    vl_i            <= '0;
    sew_i           <= VSEW_8;
    sel_operation_i <= '0;
    // Zero tail, each nonzero tail, empty length and empty select first
    set_vector(0, 32'd8, 2'd0, 3'b111);
    set_vector(1, 32'd5, 2'd0, 3'b111);
    set_vector(2, 32'd3, 2'd1, 3'b011);
    set_vector(3, 32'd7, 2'd0, 3'b101);
    set_vector(4, 32'd0, 2'd2, 3'b111);
    set_vector(5, 32'd4, 2'd2, 3'b000);
    set_vector(6, 32'd2, 2'd3, 3'b100);
    set_vector(7, 32'd1, 2'd0, 3'b010);
    for (i = 8; i < NUM_VEC; i++) begin
      rnd        = $random(seed);
      vl_tab[i]  = 32'(rnd[3:0]);
      sew_tab[i] = rnd[5:4];
      sel_tab[i] = rnd[8:6];
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(posedge clk_i);
    for (i = 0; i < NUM_VEC && timeouts == 0; i++) begin
      run_vector(i);
    end
    repeat (3) @(posedge clk_i);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+verilog
verilog/vrf_pkg.sv
verilog/vrf_iter_if.sv
verilog/vrf_iter_counter.sv
verilog/vrf_operand_regs.sv
verilog/vrf_access_fsm.sv
verilog/vrf_access_top.sv
dv/tb_vrf_access.sv

// ==== Makefile ====
# Verilator simulation of the VRF access sequencer

VERILATOR ?= verilator
TOP       ?= tb_vrf_access
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
